// ==== icache.f ====
source/icache_pkg.sv
source/icache_way.sv
source/icache_ctrl.sv
source/icache_replace.sv
source/icache_hit_merge.sv
source/icache_top.sv
tests/icache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the icache testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=icache_sim

verilator --binary --timing -Wno-fatal \
  --top-module icache_tb \
  -f icache.f \
  --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$("./$BUILD_DIR/$SIM_BIN")
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi
exit 1

// ==== tests/icache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_tb
  import icache_pkg::*;
();

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////

  localparam int NUM_ROWS = 30;
  // refill count that is not checked
  localparam logic [1:0] ANY_REFILLS = 2'd2;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 40 + 100;

  typedef struct packed {
    addr_t      addr;
    logic       flush;
    logic [1:0] refills;
  } row_t;

  // address, flush before the request, expected refills
  row_t table_rows [NUM_ROWS] = '{
    // cold line, then the rest of it streams as hits
    '{32'h0000_1000, 1'b0, 2'd1},
    '{32'h0000_1004, 1'b0, 2'd0},
    '{32'h0000_1008, 1'b0, 2'd0},
    '{32'h0000_100c, 1'b0, 2'd0},
    '{32'h0000_1000, 1'b0, 2'd0},
    // four tags fill set 5
    '{32'h0000_2054, 1'b0, 2'd1},
    '{32'h0000_3058, 1'b0, 2'd1},
    '{32'h0000_405c, 1'b0, 2'd1},
    '{32'h0000_5050, 1'b0, 2'd1},
    '{32'h0000_2050, 1'b0, 2'd0},
    '{32'h0000_3054, 1'b0, 2'd0},
    '{32'h0000_4058, 1'b0, 2'd0},
    '{32'h0000_505c, 1'b0, 2'd0},
    // fifth tag evicts a random way
    '{32'h0000_6050, 1'b0, 2'd1},
    '{32'h0000_2050, 1'b0, ANY_REFILLS},
    '{32'h0000_3050, 1'b0, ANY_REFILLS},
    '{32'h0000_4050, 1'b0, ANY_REFILLS},
    '{32'h0000_5050, 1'b0, ANY_REFILLS},
    '{32'h0000_6050, 1'b0, ANY_REFILLS},
    // cached line is gone after a flush
    '{32'h0000_1004, 1'b1, 2'd1},
    '{32'h0000_1008, 1'b0, 2'd0},
    // scattered misses under back-pressure
    '{32'h0000_7ab0, 1'b0, 2'd1},
    '{32'h0001_00f0, 1'b0, 2'd1},
    '{32'h0002_3344, 1'b0, 2'd1},
    '{32'hdead_beec, 1'b0, 2'd1},
    '{32'h8000_0020, 1'b0, 2'd1},
    '{32'h1234_5678, 1'b0, 2'd1},
    '{32'hffff_fffc, 1'b0, 2'd1},
    '{32'hdead_bee0, 1'b0, 2'd0},
    '{32'hdead_bee4, 1'b1, 2'd1}
  };

  // DUT ports
  logic  clk_i;
  logic  rst_ni;
  logic  flush_i;
  logic  busy_o;
  logic  req_valid_i;
  addr_t req_addr_i;
  logic  req_ready_o;
  logic  rsp_valid_o;
  word_t rsp_data_o;
  logic  mem_req_valid_o;
  addr_t mem_req_addr_o;
  logic  mem_req_ready_i;
  logic  mem_rtrn_valid_i;
  line_t mem_rtrn_line_i;

  // bookkeeping
  int          num_checks = 0;
  int          num_errors = 0;
  int          refill_cnt = 0;
  int          cycle_cnt;
  addr_t       cur_addr = '0;
  logic [31:0] lfsr_state = 32'h467f;

  // memory model state
  int    stall_cnt = 0;
  int    rtrn_wait = 0;
  addr_t rtrn_addr = '0;

  // refill port seen in the middle of the cycle
  logic  req_valid_s = 1'b0;
  logic  req_hs_s = 1'b0;
  addr_t req_addr_s = '0;

  // stream state
  int acc_idx;
  int rsp_idx;
  int base_cnt;
  int flushed_row;

  icache_top dut_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .busy_o           (busy_o),
    .req_valid_i      (req_valid_i),
    .req_addr_i       (req_addr_i),
    .req_ready_o      (req_ready_o),
    .rsp_valid_o      (rsp_valid_o),
    .rsp_data_o       (rsp_data_o),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_addr_o   (mem_req_addr_o),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_rtrn_valid_i (mem_rtrn_valid_i),
    .mem_rtrn_line_i  (mem_rtrn_line_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit
  function automatic int random_bits(input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = (r << 1) | int'(lfsr_state[0]);
    end
    return r;
  endfunction

  // memory holds its own byte address xor a constant
  function automatic word_t expected_word(input addr_t a);
    return {a[31:2], 2'b00} ^ 32'h5a5a_0000;
  endfunction

  function automatic line_t memory_line(input addr_t line_addr);
    line_t data;
    addr_t a;
    data = '0;
    for (int i = 0; i < WORDS_PER_LINE; i++) begin
      a = line_addr + addr_t'(4 * i);
      data[i*WORD_W +: WORD_W] = a ^ 32'h5a5a_0000;
    end
    return data;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    num_checks++;
    if (expected !== actual) begin
      num_errors++;
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // counts busy cycles of one flush sweep, sampled mid cycle
  task automatic measure_flush(input string name);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!busy_o) begin
      @(negedge clk_i);
    end
    while (busy_o) begin
      n++;
      check_value({name, " ready during flush"}, 32'd0, 32'(req_ready_o));
      check_value({name, " response during flush"}, 32'd0, 32'(rsp_valid_o));
      check_value({name, " refill during flush"}, 32'd0, 32'(mem_req_valid_o));
      @(negedge clk_i);
    end
    check_value({name, " flush cycles"}, 32'd16, 32'(n));
    check_value({name, " ready after flush"}, 32'd1, 32'(req_ready_o));
    @(posedge clk_i);
  endtask

  task automatic pulse_flush();
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    measure_flush("flush");
  endtask

  ////////////////////////////////////////
  // refill memory model
  ////////////////////////////////////////

  always @(negedge clk_i) begin
    req_valid_s = mem_req_valid_o;
    req_hs_s    = mem_req_valid_o && mem_req_ready_i;
    req_addr_s  = mem_req_addr_o;
  end

  always @(posedge clk_i) begin
    mem_rtrn_valid_i <= 1'b0;
    // return countdown from an earlier handshake
    if (rtrn_wait > 0) begin
      rtrn_wait = rtrn_wait - 1;
      if (rtrn_wait == 0) begin
        mem_rtrn_valid_i <= 1'b1;
        mem_rtrn_line_i  <= memory_line(rtrn_addr);
      end
    end
    if (req_hs_s) begin
      check_value("refill address", cur_addr & ~32'hf, req_addr_s);
      refill_cnt <= refill_cnt + 1;
      rtrn_addr = req_addr_s;
      rtrn_wait = 1 + random_bits(2);
      // ready low for 0 to 3 cycles of the next request
      stall_cnt = random_bits(2);
      mem_req_ready_i <= (stall_cnt == 0);
    end else if (req_valid_s) begin
      if (stall_cnt <= 1) begin
        mem_req_ready_i <= 1'b1;
      end
      if (stall_cnt > 0) begin
        stall_cnt = stall_cnt - 1;
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout, run did not end within %0d cycles, errors=%0d",
             TIMEOUT_CYCLES, num_errors);
    $display("Simulation finished: FAIL");
    $finish;
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    rst_ni           = 1'b0;
    flush_i          = 1'b0;
    req_valid_i      = 1'b0;
    req_addr_i       = '0;
    mem_req_ready_i  = 1'b1;
    mem_rtrn_valid_i = 1'b0;
    mem_rtrn_line_i  = '0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    measure_flush("reset");

    acc_idx     = 0;
    rsp_idx     = 0;
    base_cnt    = 0;
    flushed_row = -1;
    while (rsp_idx < NUM_ROWS) begin
      // a flush row waits until nothing is outstanding
      if (acc_idx < NUM_ROWS && table_rows[acc_idx].flush && flushed_row != acc_idx) begin
        req_valid_i <= 1'b0;
        if (rsp_idx == acc_idx) begin
          pulse_flush();
          flushed_row = acc_idx;
        end
      end
      if (acc_idx < NUM_ROWS && !(table_rows[acc_idx].flush && flushed_row != acc_idx)) begin
        req_valid_i <= 1'b1;
        req_addr_i  <= table_rows[acc_idx].addr;
      end else begin
        req_valid_i <= 1'b0;
      end
      @(negedge clk_i);
      // response belongs to the oldest accepted row
      if (rsp_valid_o) begin
        if (rsp_idx >= acc_idx) begin
          num_errors++;
          $display("response arrived with no request outstanding");
        end else begin
          check_value($sformatf("row %0d data", rsp_idx),
                      expected_word(table_rows[rsp_idx].addr), rsp_data_o);
          if (table_rows[rsp_idx].refills != ANY_REFILLS) begin
            check_value($sformatf("row %0d refills", rsp_idx),
                        32'(table_rows[rsp_idx].refills), 32'(refill_cnt - base_cnt));
          end
          rsp_idx++;
        end
      end
      // handshake happens at the coming edge
      if (req_valid_i && req_ready_o) begin
        cur_addr = table_rows[acc_idx].addr;
        base_cnt = refill_cnt;
        acc_idx++;
      end
      @(posedge clk_i);
    end

    // nothing more may come back
    req_valid_i <= 1'b0;
    repeat (8) begin
      @(negedge clk_i);
      check_value("extra response", 32'd0, 32'(rsp_valid_o));
      check_value("extra refill", 32'd0, 32'(mem_req_valid_o));
    end

    $display("checks=%0d errors=%0d refills=%0d", num_checks, num_errors, refill_cnt);
    if (num_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top
  import icache_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  flush_i,
  output logic  busy_o,
  input  logic  req_valid_i,
  input  addr_t req_addr_i,
  output logic  req_ready_o,
  output logic  rsp_valid_o,
  output word_t rsp_data_o,
  output logic  mem_req_valid_o,
  output addr_t mem_req_addr_o,
  input  logic  mem_req_ready_i,
  input  logic  mem_rtrn_valid_i,
  input  line_t mem_rtrn_line_i
);

  // array control from the controller
  set_idx_t  rd_set;
  logic      rd_en;
  logic      clr_en;
  logic      fill_en;
  tag_t      cmp_tag;
  word_off_t cmp_off;
  logic      lookup;
  logic      use_refill;
  logic      hit;

  // per way results
  way_oh_t              victim_oh;
  way_oh_t              way_valid;
  way_oh_t              way_hit;
  word_t [NUM_WAYS-1:0] way_word;

  ////////////////////////////////////////
  // control and replacement
  ////////////////////////////////////////

  icache_ctrl i_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .req_valid_i      (req_valid_i),
    .req_addr_i       (req_addr_i),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_rtrn_valid_i (mem_rtrn_valid_i),
    .hit_i            (hit),
    .busy_o           (busy_o),
    .req_ready_o      (req_ready_o),
    .rsp_valid_o      (rsp_valid_o),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_addr_o   (mem_req_addr_o),
    .rd_set_o         (rd_set),
    .rd_en_o          (rd_en),
    .clr_en_o         (clr_en),
    .fill_en_o        (fill_en),
    .cmp_tag_o        (cmp_tag),
    .cmp_off_o        (cmp_off),
    .lookup_o         (lookup),
    .use_refill_o     (use_refill)
  );

  icache_replace i_replace (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .way_valid_i (way_valid),
    .lookup_i    (lookup),
    .fill_en_i   (fill_en),
    .victim_oh_o (victim_oh)
  );

  ////////////////////////////////////////
  // ways and response merge
  ////////////////////////////////////////

  for (genvar g = 0; g < NUM_WAYS; g++) begin : gen_way
    icache_way i_way (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .rd_set_i    (rd_set),
      .rd_en_i     (rd_en),
      .clr_en_i    (clr_en),
      .fill_en_i   (fill_en),
      .fill_sel_i  (victim_oh[g]),
      .cmp_tag_i   (cmp_tag),
      .cmp_off_i   (cmp_off),
      .fill_line_i (mem_rtrn_line_i),
      .valid_o     (way_valid[g]),
      .hit_o       (way_hit[g]),
      .word_o      (way_word[g])
    );
  end

  icache_hit_merge i_merge (
    .way_hit_i     (way_hit),
    .way_word_i    (way_word),
    .use_refill_i  (use_refill),
    .refill_line_i (mem_rtrn_line_i),
    .cmp_off_i     (cmp_off),
    .hit_o         (hit),
    .rsp_data_o    (rsp_data_o)
  );

endmodule

`default_nettype wire

// ==== source/icache_hit_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_hit_merge
  import icache_pkg::*;
(
  input  way_oh_t               way_hit_i,
  input  word_t [NUM_WAYS-1:0]  way_word_i,
  input  logic                  use_refill_i,
  input  line_t                 refill_line_i,
  input  word_off_t             cmp_off_i,
  output logic                  hit_o,
  output word_t                 rsp_data_o
);

  word_t hit_word;
  word_t refill_word;

  // any way hitting is a hit
  assign hit_o = |way_hit_i;

  // priority encode, lowest way wins
  always_comb begin
    hit_word = '0;
    for (int i = NUM_WAYS - 1; i >= 0; i--) begin
      if (way_hit_i[i]) begin
        hit_word = way_word_i[i];
      end
    end
  end

  // word straight from the refill line on a miss
  assign refill_word = refill_line_i[{cmp_off_i, 5'b0} +: WORD_W];

  assign rsp_data_o = use_refill_i ? refill_word : hit_word;

endmodule

`default_nettype wire

// ==== source/icache_replace.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_replace
  import icache_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  way_oh_t way_valid_i,
  input  logic    lookup_i,
  input  logic    fill_en_i,
  output way_oh_t victim_oh_o
);

  logic [LFSR_W-1:0] lfsr_q;
  logic              lfsr_fb;
  logic              all_valid;
  way_oh_t           inv_oh;
  way_idx_t          rnd_way;
  way_oh_t           victim_d, victim_q;

  assign all_valid = &way_valid_i;

  // lowest numbered invalid way wins
  always_comb begin
    inv_oh = '0;
    for (int i = NUM_WAYS - 1; i >= 0; i--) begin
      if (!way_valid_i[i]) begin
        inv_oh    = '0;
        inv_oh[i] = 1'b1;
      end
    end
  end

  // fibonacci taps 8,6,5,4
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
  assign rnd_way = lfsr_q[WAY_W-1:0];

  assign victim_d = all_valid ? (way_oh_t'(1) << rnd_way) : inv_oh;

  // step only when a random victim was actually used
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= '1;
    end else if (fill_en_i && all_valid) begin
      lfsr_q <= {lfsr_q[LFSR_W-2:0], lfsr_fb};
    end
  end

  // victim frozen after the compare cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      victim_q <= '0;
    end else if (lookup_i) begin
      victim_q <= victim_d;
    end
  end

  assign victim_oh_o = victim_q;

endmodule

`default_nettype wire

// ==== source/icache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl
  import icache_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      flush_i,
  input  logic      req_valid_i,
  input  addr_t     req_addr_i,
  input  logic      mem_req_ready_i,
  input  logic      mem_rtrn_valid_i,
  input  logic      hit_i,
  output logic      busy_o,
  output logic      req_ready_o,
  output logic      rsp_valid_o,
  output logic      mem_req_valid_o,
  output addr_t     mem_req_addr_o,
  output set_idx_t  rd_set_o,
  output logic      rd_en_o,
  output logic      clr_en_o,
  output logic      fill_en_o,
  output tag_t      cmp_tag_o,
  output word_off_t cmp_off_o,
  output logic      lookup_o,
  output logic      use_refill_o
);

  // FLUSH clears valid bits, READ is the compare cycle
  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } state_e;

  state_e   state_d, state_q;
  logic     flush_d, flush_q;
  set_idx_t flush_cnt_d, flush_cnt_q;
  logic     flush_done;

  // request fields
  tag_t      req_tag;
  set_idx_t  req_set;
  word_off_t req_off;
  logic      accept;

  // latched request
  tag_t      tag_q;
  set_idx_t  set_q;
  word_off_t off_q;

  ////////////////////////////////////////
  // address split
  ////////////////////////////////////////

  assign req_tag = req_addr_i[ADDR_W-1 -: TAG_W];
  assign req_set = req_addr_i[BYTE_OFF_W +: SET_W];
  // low two bits select the byte and are ignored
  assign req_off = req_addr_i[BYTE_OFF_W-OFF_W +: OFF_W];

  assign accept = req_valid_i & req_ready_o;

  // last set of the sweep
  assign flush_done = (flush_cnt_q == set_idx_t'(NUM_SETS - 1));

  ////////////////////////////////////////
  // state machine
  ////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    // keep a flush pulse until it is served
    flush_d         = flush_q | flush_i;
    flush_cnt_d     = flush_cnt_q;
    req_ready_o     = 1'b0;
    rsp_valid_o     = 1'b0;
    mem_req_valid_o = 1'b0;
    rd_en_o         = 1'b0;
    clr_en_o        = 1'b0;
    fill_en_o       = 1'b0;
    lookup_o        = 1'b0;
    use_refill_o    = 1'b0;

    unique case (state_q)
      // one set per cycle
      FLUSH: begin
        clr_en_o    = 1'b1;
        flush_cnt_d = flush_cnt_q + 1'b1;
        if (flush_done) begin
          state_d     = IDLE;
          flush_d     = 1'b0;
          flush_cnt_d = '0;
        end
      end
      // wait for a request or act on a pending flush
      IDLE: begin
        if (flush_d) begin
          state_d = FLUSH;
        end else begin
          req_ready_o = 1'b1;
          if (req_valid_i) begin
            rd_en_o = 1'b1;
            state_d = READ;
          end
        end
      end
      // tag compare on the registered read
      READ: begin
        lookup_o = 1'b1;
        if (hit_i) begin
          rsp_valid_o = 1'b1;
          state_d     = IDLE;
          // stream the next request while this one answers
          if (!flush_d) begin
            req_ready_o = 1'b1;
            if (req_valid_i) begin
              rd_en_o = 1'b1;
              state_d = READ;
            end
          end
        end else begin
          // read regs hold, so the request can wait for ready
          mem_req_valid_o = 1'b1;
          if (mem_req_ready_i) begin
            state_d = MISS;
          end
        end
      end
      // refill return is always taken
      MISS: begin
        use_refill_o = 1'b1;
        if (mem_rtrn_valid_i) begin
          rsp_valid_o = 1'b1;
          fill_en_o   = 1'b1;
          state_d     = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  // flush walks the counter, a new request its own set
  assign rd_set_o = (state_q == FLUSH) ? flush_cnt_q :
                    accept             ? req_set     :
                                         set_q;

  assign busy_o         = (state_q != IDLE);
  assign cmp_tag_o      = tag_q;
  assign cmp_off_o      = off_q;
  // refill is line aligned
  assign mem_req_addr_o = {tag_q, set_q, {BYTE_OFF_W{1'b0}}};

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q     <= state_d;
      flush_q     <= flush_d;
      flush_cnt_q <= flush_cnt_d;
    end
  end

  // request fields captured at the handshake
  always_ff @(posedge clk_i) begin
    if (accept) begin
      tag_q <= req_tag;
      set_q <= req_set;
      off_q <= req_off;
    end
  end

endmodule

`default_nettype wire

// ==== source/icache_way.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_way
  import icache_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  set_idx_t  rd_set_i,
  input  logic      rd_en_i,
  input  logic      clr_en_i,
  input  logic      fill_en_i,
  input  logic      fill_sel_i,
  input  tag_t      cmp_tag_i,
  input  word_off_t cmp_off_i,
  input  line_t     fill_line_i,
  output logic      valid_o,
  output logic      hit_o,
  output word_t     word_o
);

  ////////////////////////////////////////
  // arrays
  ////////////////////////////////////////

  // one entry per set
  tag_t  tag_mem   [NUM_SETS];
  logic  valid_mem [NUM_SETS];
  line_t line_mem  [NUM_SETS];

  // registered read port
  tag_t  tag_rd_q;
  line_t line_rd_q;
  logic  valid_rd_q;

  logic  fill_we;

  // only the victim way takes the refill line
  assign fill_we = fill_en_i & fill_sel_i;

  // clear and fill share the set index with the read port
  always_ff @(posedge clk_i) begin
    if (clr_en_i) begin
      valid_mem[rd_set_i] <= 1'b0;
    end else if (fill_we) begin
      valid_mem[rd_set_i] <= 1'b1;
    end
    if (fill_we) begin
      tag_mem[rd_set_i]  <= cmp_tag_i;
      line_mem[rd_set_i] <= fill_line_i;
    end
  end

  // one cycle read latency, data held while rd_en_i is low
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      tag_rd_q  <= tag_mem[rd_set_i];
      line_rd_q <= line_mem[rd_set_i];
    end
  end

  // read valid starts cleared so nothing hits before the first lookup
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_rd_q <= 1'b0;
    end else if (rd_en_i) begin
      valid_rd_q <= valid_mem[rd_set_i];
    end
  end

  ////////////////////////////////////////
  // compare and word select
  ////////////////////////////////////////

  assign valid_o = valid_rd_q;
  // tag from the latched request
  assign hit_o   = valid_rd_q & (tag_rd_q == cmp_tag_i);
  assign word_o  = line_rd_q[{cmp_off_i, 5'b0} +: WORD_W];

endmodule

`default_nettype wire

// ==== source/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

  ////////////////////////////////////////
  // geometry
  ////////////////////////////////////////

  // fetch and refill addresses are physical byte addresses
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;

  // four ways, sixteen sets of sixteen byte lines
  localparam int NUM_WAYS = 4;
  localparam int WAY_W = 2;
  localparam int NUM_SETS = 16;
  localparam int SET_W = 4;
  localparam int WORDS_PER_LINE = 4;
  // word offset inside a line
  localparam int OFF_W = 2;
  localparam int BYTE_OFF_W = 4;
  localparam int TAG_W = ADDR_W - SET_W - BYTE_OFF_W;
  localparam int LINE_W = WORDS_PER_LINE * WORD_W;

  // replacement lfsr width
  localparam int LFSR_W = 8;

  ////////////////////////////////////////
  // vector types
  ////////////////////////////////////////

  typedef logic [ADDR_W-1:0] addr_t;
  // address bits 31..8
  typedef logic [TAG_W-1:0] tag_t;
  // address bits 7..4
  typedef logic [SET_W-1:0] set_idx_t;
  // address bits 3..2
  typedef logic [OFF_W-1:0] word_off_t;
  typedef logic [WORD_W-1:0] word_t;
  // word 0 sits in the low bits
  typedef logic [LINE_W-1:0] line_t;
  typedef logic [NUM_WAYS-1:0] way_oh_t;
  typedef logic [WAY_W-1:0] way_idx_t;

endpackage

`default_nettype wire
